// ==== hw/mem_unit_pkg.sv ====
`default_nettype none

package mem_unit_pkg;

    localparam int ADDR_W     = 16;
    localparam int DATA_W     = 32;
    localparam int BYTES      = 4;
    localparam int TAG_W      = 4;
    localparam int SMEM_DEPTH = 256;
    localparam int CTR_W      = 32;

    // Upper address bits that select the shared-memory window
    localparam int SMEM_SEL_W = 8;
    localparam logic [SMEM_SEL_W-1:0] SMEM_BASE = 8'hFF;

    // Source bit kept in the low position of the memory tag
    localparam logic SRC_FETCH = 1'b0;
    localparam logic SRC_DATA  = 1'b1;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [BYTES-1:0]  byteen_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [TAG_W:0]    mem_tag_t;
    typedef logic [CTR_W-1:0]  ctr_t;

    typedef struct packed {
        logic    rw;
        byteen_t byteen;
        addr_t   addr;
        data_t   data;
        tag_t    tag;
    } core_req_t;

    typedef struct packed {
        data_t data;
        tag_t  tag;
    } core_rsp_t;

    // Same as the core request with the source bit appended to the tag
    typedef struct packed {
        logic     rw;
        byteen_t  byteen;
        addr_t    addr;
        data_t    data;
        mem_tag_t mem_tag;
    } mem_req_t;

    typedef struct packed {
        data_t    data;
        mem_tag_t mem_tag;
    } mem_rsp_t;

    typedef struct packed {
        ctr_t reads;
        ctr_t writes;
        ctr_t stalls;
        ctr_t latency;
    } perf_t;

endpackage

`default_nettype wire

// ==== hw/smem_router.sv ====
`default_nettype none

module smem_router (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   req_valid,
    input  mem_unit_pkg::core_req_t req,
    output logic                   req_ready,

    output logic                   rsp_valid,
    output mem_unit_pkg::core_rsp_t rsp,
    input  logic                   rsp_ready,

    output logic                   smem_req_valid,
    output mem_unit_pkg::core_req_t smem_req,
    input  logic                   smem_req_ready,

    input  logic                   smem_rsp_valid,
    input  mem_unit_pkg::core_rsp_t smem_rsp,
    output logic                   smem_rsp_ready,

    output logic                   ext_req_valid,
    output mem_unit_pkg::core_req_t ext_req,
    input  logic                   ext_req_ready,

    input  logic                   ext_rsp_valid,
    input  mem_unit_pkg::core_rsp_t ext_rsp,
    output logic                   ext_rsp_ready
);

    logic is_smem;

    // Window decode on the top address bits
    assign is_smem = req.addr[mem_unit_pkg::ADDR_W-1 -: mem_unit_pkg::SMEM_SEL_W]
                     == mem_unit_pkg::SMEM_BASE;

    assign smem_req_valid = req_valid && is_smem;
    assign ext_req_valid  = req_valid && !is_smem;
    assign smem_req       = req;
    assign ext_req        = req;
    assign req_ready      = is_smem ? smem_req_ready : ext_req_ready;

    // Shared memory wins the response merge and external waits
    assign rsp_valid      = smem_rsp_valid || ext_rsp_valid;
    assign rsp            = smem_rsp_valid ? smem_rsp : ext_rsp;
    assign smem_rsp_ready = rsp_ready;
    assign ext_rsp_ready  = rsp_ready && !smem_rsp_valid;

    // A stalled request holds so its target stays fixed
    a_req_held: assert property (
        @(posedge clk) disable iff (reset)
        (req_valid && !req_ready) |=> (req_valid && $stable(req))
    );

endmodule

`default_nettype wire

// ==== hw/shared_mem.sv ====
`default_nettype none

module shared_mem (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   req_valid,
    input  mem_unit_pkg::core_req_t req,
    output logic                   req_ready,

    output logic                   rsp_valid,
    output mem_unit_pkg::core_rsp_t rsp,
    input  logic                   rsp_ready
);

    localparam int IDX_W = $clog2(mem_unit_pkg::SMEM_DEPTH);

    mem_unit_pkg::data_t mem [mem_unit_pkg::SMEM_DEPTH];

    logic [IDX_W-1:0] idx;
    logic             rd_fire;
    logic             wr_fire;

    assign idx = req.addr[IDX_W-1:0];

    // Stall only while a read response sits unclaimed
    assign req_ready = !rsp_valid || rsp_ready;
    assign rd_fire   = req_valid && req_ready && !req.rw;
    assign wr_fire   = req_valid && req_ready && req.rw;

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int i = 0; i < mem_unit_pkg::BYTES; i++) begin
                if (req.byteen[i]) begin
                    mem[idx][i*8 +: 8] <= req.data[i*8 +: 8];
                end
            end
        end
    end

    // One-entry response register
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (rd_fire) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rsp.data <= mem[idx];
            rsp.tag  <= req.tag;
        end
    end

    a_rsp_held: assert property (
        @(posedge clk) disable iff (reset)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp))
    );

endmodule

`default_nettype wire

// ==== hw/mem_arb.sv ====
`default_nettype none

module mem_arb (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   fetch_req_valid,
    input  mem_unit_pkg::core_req_t fetch_req,
    output logic                   fetch_req_ready,

    output logic                   fetch_rsp_valid,
    output mem_unit_pkg::core_rsp_t fetch_rsp,
    input  logic                   fetch_rsp_ready,

    input  logic                   data_req_valid,
    input  mem_unit_pkg::core_req_t data_req,
    output logic                   data_req_ready,

    output logic                   data_rsp_valid,
    output mem_unit_pkg::core_rsp_t data_rsp,
    input  logic                   data_rsp_ready,

    output logic                   mem_req_valid,
    output mem_unit_pkg::mem_req_t mem_req,
    input  logic                   mem_req_ready,

    input  logic                   mem_rsp_valid,
    input  mem_unit_pkg::mem_rsp_t mem_rsp,
    output logic                   mem_rsp_ready
);

    // Set when data has priority on the next conflict
    logic                    prio_data;
    // Grant frozen while the mem port stalls
    logic                    locked;
    logic                    locked_data;
    logic                    grant_fetch;
    logic                    grant_data;
    logic                    rsp_src;
    mem_unit_pkg::core_req_t win;

    assign grant_data  = locked ? locked_data
                                : data_req_valid && (!fetch_req_valid || prio_data);
    assign grant_fetch = fetch_req_valid && !grant_data;

    assign fetch_req_ready = grant_fetch && mem_req_ready;
    assign data_req_ready  = grant_data && mem_req_ready;

    assign win           = grant_data ? data_req : fetch_req;
    assign mem_req_valid = fetch_req_valid || data_req_valid;

    always_comb begin
        mem_req.rw      = win.rw;
        mem_req.byteen  = win.byteen;
        mem_req.addr    = win.addr;
        mem_req.data    = win.data;
        mem_req.mem_tag = {win.tag, grant_data ? mem_unit_pkg::SRC_DATA
                                               : mem_unit_pkg::SRC_FETCH};
    end

    // Pointer flips away from whoever just transferred
    always_ff @(posedge clk) begin
        if (reset) begin
            prio_data <= 1'b0;
        end else if (mem_req_valid && mem_req_ready) begin
            prio_data <= grant_fetch;
        end
    end

    // Keep the stalled winner so a late arrival cannot swap the payload
    always_ff @(posedge clk) begin
        if (reset) begin
            locked      <= 1'b0;
            locked_data <= 1'b0;
        end else begin
            locked      <= mem_req_valid && !mem_req_ready;
            locked_data <= grant_data;
        end
    end

    assign rsp_src = mem_rsp.mem_tag[0];

    assign fetch_rsp_valid = mem_rsp_valid && (rsp_src == mem_unit_pkg::SRC_FETCH);
    assign data_rsp_valid  = mem_rsp_valid && (rsp_src == mem_unit_pkg::SRC_DATA);
    assign fetch_rsp.data  = mem_rsp.data;
    assign fetch_rsp.tag   = mem_rsp.mem_tag[mem_unit_pkg::TAG_W:1];
    assign data_rsp.data   = mem_rsp.data;
    assign data_rsp.tag    = mem_rsp.mem_tag[mem_unit_pkg::TAG_W:1];
    assign mem_rsp_ready   = (rsp_src == mem_unit_pkg::SRC_DATA) ? data_rsp_ready
                                                                 : fetch_rsp_ready;

    a_grant_valid: assert property (
        @(posedge clk) disable iff (reset)
        grant_data |-> data_req_valid
    );

    a_mem_req_held: assert property (
        @(posedge clk) disable iff (reset)
        (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req))
    );

endmodule

`default_nettype wire

// ==== hw/mem_perf_counters.sv ====
`default_nettype none

module mem_perf_counters (
    input  logic                clk,
    input  logic                reset,

    input  logic                mem_req_valid,
    input  logic                mem_req_ready,
    input  logic                mem_req_rw,

    input  logic                mem_rsp_valid,
    input  logic                mem_rsp_ready,

    output mem_unit_pkg::perf_t perf
);

    mem_unit_pkg::ctr_t outstanding;

    logic req_fire;
    logic rd_fire;
    logic rsp_fire;

    assign req_fire = mem_req_valid && mem_req_ready;
    assign rd_fire  = req_fire && !mem_req_rw;
    assign rsp_fire = mem_rsp_valid && mem_rsp_ready;

    // Reads in flight, only reads ever get a response
    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= '0;
        end else if (rd_fire && !rsp_fire) begin
            outstanding <= outstanding + 1'b1;
        end else if (rsp_fire && !rd_fire) begin
            outstanding <= outstanding - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            perf <= '0;
        end else begin
            if (rd_fire) begin
                perf.reads <= perf.reads + 1'b1;
            end
            if (req_fire && mem_req_rw) begin
                perf.writes <= perf.writes + 1'b1;
            end
            if (mem_req_valid && !mem_req_ready) begin
                perf.stalls <= perf.stalls + 1'b1;
            end
            // Sum of the in-flight count before this edge
            perf.latency <= perf.latency + outstanding;
        end
    end

    a_no_underflow: assert property (
        @(posedge clk) disable iff (reset)
        rsp_fire |-> (outstanding != '0)
    );

endmodule

`default_nettype wire

// ==== hw/mem_unit.sv ====
`default_nettype none

module mem_unit (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   fetch_req_valid,
    input  mem_unit_pkg::addr_t    fetch_addr,
    input  mem_unit_pkg::tag_t     fetch_tag,
    output logic                   fetch_req_ready,

    output logic                   fetch_rsp_valid,
    output mem_unit_pkg::core_rsp_t fetch_rsp,
    input  logic                   fetch_rsp_ready,

    input  logic                   data_req_valid,
    input  mem_unit_pkg::core_req_t data_req,
    output logic                   data_req_ready,

    output logic                   data_rsp_valid,
    output mem_unit_pkg::core_rsp_t data_rsp,
    input  logic                   data_rsp_ready,

    output logic                   mem_req_valid,
    output mem_unit_pkg::mem_req_t mem_req,
    input  logic                   mem_req_ready,

    input  logic                   mem_rsp_valid,
    input  mem_unit_pkg::mem_rsp_t mem_rsp,
    output logic                   mem_rsp_ready,

    output mem_unit_pkg::perf_t    perf
);

    mem_unit_pkg::core_req_t fetch_req;

    logic                    smem_req_valid;
    mem_unit_pkg::core_req_t smem_req;
    logic                    smem_req_ready;
    logic                    smem_rsp_valid;
    mem_unit_pkg::core_rsp_t smem_rsp;
    logic                    smem_rsp_ready;

    logic                    ext_req_valid;
    mem_unit_pkg::core_req_t ext_req;
    logic                    ext_req_ready;
    logic                    ext_rsp_valid;
    mem_unit_pkg::core_rsp_t ext_rsp;
    logic                    ext_rsp_ready;

    // Fetches are always full-word reads
    always_comb begin
        fetch_req.rw     = 1'b0;
        fetch_req.byteen = '1;
        fetch_req.addr   = fetch_addr;
        fetch_req.data   = '0;
        fetch_req.tag    = fetch_tag;
    end

    smem_router router (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (data_req_valid),
        .req            (data_req),
        .req_ready      (data_req_ready),
        .rsp_valid      (data_rsp_valid),
        .rsp            (data_rsp),
        .rsp_ready      (data_rsp_ready),
        .smem_req_valid (smem_req_valid),
        .smem_req       (smem_req),
        .smem_req_ready (smem_req_ready),
        .smem_rsp_valid (smem_rsp_valid),
        .smem_rsp       (smem_rsp),
        .smem_rsp_ready (smem_rsp_ready),
        .ext_req_valid  (ext_req_valid),
        .ext_req        (ext_req),
        .ext_req_ready  (ext_req_ready),
        .ext_rsp_valid  (ext_rsp_valid),
        .ext_rsp        (ext_rsp),
        .ext_rsp_ready  (ext_rsp_ready)
    );

    shared_mem smem (
        .clk       (clk),
        .reset     (reset),
        .req_valid (smem_req_valid),
        .req       (smem_req),
        .req_ready (smem_req_ready),
        .rsp_valid (smem_rsp_valid),
        .rsp       (smem_rsp),
        .rsp_ready (smem_rsp_ready)
    );

    mem_arb arb (
        .clk             (clk),
        .reset           (reset),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req       (fetch_req),
        .fetch_req_ready (fetch_req_ready),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp       (fetch_rsp),
        .fetch_rsp_ready (fetch_rsp_ready),
        .data_req_valid  (ext_req_valid),
        .data_req        (ext_req),
        .data_req_ready  (ext_req_ready),
        .data_rsp_valid  (ext_rsp_valid),
        .data_rsp        (ext_rsp),
        .data_rsp_ready  (ext_rsp_ready),
        .mem_req_valid   (mem_req_valid),
        .mem_req         (mem_req),
        .mem_req_ready   (mem_req_ready),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp         (mem_rsp),
        .mem_rsp_ready   (mem_rsp_ready)
    );

    mem_perf_counters counters (
        .clk           (clk),
        .reset         (reset),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_rw    (mem_req.rw),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .perf          (perf)
    );

endmodule

`default_nettype wire

// ==== test/tb_mem_unit.sv ====
`default_nettype none

module tb_mem_unit;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_OPS    = 32;
    localparam int WAIT_LIMIT = 200;
    localparam int LINE_W     = 92;

    localparam logic [3:0] OP_FETCH = 4'h1;
    localparam logic [3:0] OP_LOAD  = 4'h2;
    localparam logic [3:0] OP_STORE = 4'h3;
    localparam logic [3:0] OP_PAIR  = 4'h4;
    localparam logic [3:0] OP_FINAL = 4'hF;

    // One line of the data file
    typedef struct packed {
        logic [3:0]            op;
        mem_unit_pkg::addr_t   addr;
        mem_unit_pkg::byteen_t byteen;
        mem_unit_pkg::data_t   data;
        mem_unit_pkg::tag_t    tag;
        mem_unit_pkg::data_t   expected;
    } op_line_t;

    logic                    clk             = 1'b0;
    logic                    reset           = 1'b1;
    logic                    fetch_req_valid = 1'b0;
    mem_unit_pkg::addr_t     fetch_addr      = '0;
    mem_unit_pkg::tag_t      fetch_tag       = '0;
    logic                    fetch_req_ready;
    logic                    fetch_rsp_valid;
    mem_unit_pkg::core_rsp_t fetch_rsp;
    logic                    fetch_rsp_ready = 1'b0;
    logic                    data_req_valid  = 1'b0;
    mem_unit_pkg::core_req_t data_req        = '0;
    logic                    data_req_ready;
    logic                    data_rsp_valid;
    mem_unit_pkg::core_rsp_t data_rsp;
    logic                    data_rsp_ready  = 1'b0;
    logic                    mem_req_valid;
    mem_unit_pkg::mem_req_t  mem_req;
    logic                    mem_req_ready   = 1'b0;
    logic                    mem_rsp_valid   = 1'b0;
    mem_unit_pkg::mem_rsp_t  mem_rsp         = '0;
    logic                    mem_rsp_ready;
    mem_unit_pkg::perf_t     perf;

    logic [LINE_W-1:0] ops [MAX_OPS];

    mem_unit_pkg::core_rsp_t fetch_exp [$];
    mem_unit_pkg::core_rsp_t data_exp [$];

    // External memory model state
    mem_unit_pkg::data_t    ext_words [mem_unit_pkg::addr_t];
    mem_unit_pkg::mem_rsp_t rsp_q [$];
    int                     due_q [$];
    int                     cycle;
    logic [15:0]            lfsr = 16'd52411;

    int   n_reads;
    int   n_writes;
    int   n_stalls;
    int   n_fetch_xfers;
    int   n_data_xfers;
    int   outstanding;
    int   lat_sum;
    logic last_src;

    always #5 clk = ~clk;

    mem_unit UUT (
        .clk             (clk),
        .reset           (reset),
        .fetch_req_valid (fetch_req_valid),
        .fetch_addr      (fetch_addr),
        .fetch_tag       (fetch_tag),
        .fetch_req_ready (fetch_req_ready),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp       (fetch_rsp),
        .fetch_rsp_ready (fetch_rsp_ready),
        .data_req_valid  (data_req_valid),
        .data_req        (data_req),
        .data_req_ready  (data_req_ready),
        .data_rsp_valid  (data_rsp_valid),
        .data_rsp        (data_rsp),
        .data_rsp_ready  (data_rsp_ready),
        .mem_req_valid   (mem_req_valid),
        .mem_req         (mem_req),
        .mem_req_ready   (mem_req_ready),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp         (mem_rsp),
        .mem_rsp_ready   (mem_rsp_ready),
        .perf            (perf)
    );

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic take_bit();
        lfsr = lfsr_step(lfsr);
        return lfsr[0];
    endfunction

    function automatic mem_unit_pkg::data_t fill_word(input mem_unit_pkg::addr_t a);
        return {a, a} ^ 32'hA5A5A5A5;
    endfunction

    function automatic mem_unit_pkg::data_t read_word(input mem_unit_pkg::addr_t a);
        if (ext_words.exists(a)) begin
            return ext_words[a];
        end
        return fill_word(a);
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "Simulation stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            stop_on_error($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, want));
        end
    endtask

    // External memory model with in-order reads after 1 to 3 cycles
    always @(posedge clk) begin
        mem_unit_pkg::data_t word;
        int                  delay;
        if (reset) begin
            mem_req_ready   <= 1'b0;
            mem_rsp_valid   <= 1'b0;
            fetch_rsp_ready <= 1'b0;
            data_rsp_ready  <= 1'b0;
            cycle = 0;
        end else begin
            cycle++;
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req.rw) begin
                    word = read_word(mem_req.addr);
                    for (int i = 0; i < mem_unit_pkg::BYTES; i++) begin
                        if (mem_req.byteen[i]) begin
                            word[i*8 +: 8] = mem_req.data[i*8 +: 8];
                        end
                    end
                    ext_words[mem_req.addr] = word;
                end else begin
                    delay = 2 * int'(take_bit());
                    delay = (delay + int'(take_bit())) % 3;
                    rsp_q.push_back({read_word(mem_req.addr), mem_req.mem_tag});
                    due_q.push_back(cycle + delay);
                end
            end
            if (mem_rsp_valid && mem_rsp_ready) begin
                void'(rsp_q.pop_front());
                void'(due_q.pop_front());
            end
            if (rsp_q.size() != 0 && due_q[0] <= cycle) begin
                mem_rsp_valid <= 1'b1;
                mem_rsp       <= rsp_q[0];
            end else begin
                mem_rsp_valid <= 1'b0;
            end
            mem_req_ready   <= take_bit();
            fetch_rsp_ready <= take_bit();
            data_rsp_ready  <= take_bit();
        end
    end

    // Port monitor with own counts and response checks
    always @(posedge clk) begin
        mem_unit_pkg::core_rsp_t want;
        logic                    src;
        if (reset) begin
            n_reads       = 0;
            n_writes      = 0;
            n_stalls      = 0;
            n_fetch_xfers = 0;
            n_data_xfers  = 0;
            outstanding   = 0;
            lat_sum       = 0;
            last_src      = mem_unit_pkg::SRC_DATA;
        end else begin
            lat_sum += outstanding;
            if (mem_req_valid && !mem_req_ready) begin
                n_stalls++;
            end
            if (mem_req_valid && mem_req_ready) begin
                src = mem_req.mem_tag[0];
                // Both sources waiting means the grant must flip
                if (fetch_req_valid && data_req_valid &&
                    data_req.addr[15:8] != mem_unit_pkg::SMEM_BASE) begin
                    check_value("mem_req.mem_tag[0]", 32'(src), 32'(!last_src));
                end
                last_src = src;
                if (src == mem_unit_pkg::SRC_FETCH) begin
                    assert (fetch_req_valid) else begin
                        stop_on_error("A fetch request reached the mem port with none pending");
                    end
                    n_fetch_xfers++;
                    check_value("mem_req.rw", 32'(mem_req.rw), 32'(0));
                    check_value("mem_req.byteen", 32'(mem_req.byteen), 32'hF);
                    check_value("mem_req.addr", 32'(mem_req.addr), 32'(fetch_addr));
                    check_value("mem_req.data", mem_req.data, 32'h0);
                    check_value("mem_req.mem_tag", 32'(mem_req.mem_tag[4:1]), 32'(fetch_tag));
                end else begin
                    assert (data_req_valid) else begin
                        stop_on_error("A data request reached the mem port with none pending");
                    end
                    n_data_xfers++;
                    check_value("mem_req.rw", 32'(mem_req.rw), 32'(data_req.rw));
                    check_value("mem_req.byteen", 32'(mem_req.byteen), 32'(data_req.byteen));
                    check_value("mem_req.addr", 32'(mem_req.addr), 32'(data_req.addr));
                    check_value("mem_req.data", mem_req.data, data_req.data);
                    check_value("mem_req.mem_tag", 32'(mem_req.mem_tag[4:1]), 32'(data_req.tag));
                end
                if (mem_req.rw) begin
                    n_writes++;
                end else begin
                    n_reads++;
                    outstanding++;
                end
            end
            if (mem_rsp_valid && mem_rsp_ready) begin
                outstanding--;
            end
            if (fetch_rsp_valid && fetch_rsp_ready) begin
                assert (fetch_exp.size() != 0) else begin
                    stop_on_error("Unexpected response on fetch_rsp");
                end
                want = fetch_exp.pop_front();
                check_value("fetch_rsp.data", fetch_rsp.data, want.data);
                check_value("fetch_rsp.tag", 32'(fetch_rsp.tag), 32'(want.tag));
            end
            if (data_rsp_valid && data_rsp_ready) begin
                assert (data_exp.size() != 0) else begin
                    stop_on_error("Unexpected response on data_rsp");
                end
                want = data_exp.pop_front();
                check_value("data_rsp.data", data_rsp.data, want.data);
                check_value("data_rsp.tag", 32'(data_rsp.tag), 32'(want.tag));
            end
        end
    end

    // Called right after a rising edge
    task automatic issue_requests(input logic do_fetch, input logic do_data,
                                  input op_line_t line, input mem_unit_pkg::core_req_t req);
        int   waited;
        logic fetch_done;
        logic data_done;
        waited     = 0;
        fetch_done = !do_fetch;
        data_done  = !do_data;
        if (do_fetch) begin
            fetch_req_valid <= 1'b1;
            fetch_addr      <= line.addr;
            fetch_tag       <= line.tag;
        end
        if (do_data) begin
            data_req_valid <= 1'b1;
            data_req       <= req;
        end
        while (!(fetch_done && data_done)) begin
            @(posedge clk);
            if (fetch_req_valid && fetch_req_ready) begin
                fetch_done = 1'b1;
                fetch_req_valid <= 1'b0;
            end
            if (data_req_valid && data_req_ready) begin
                data_done = 1'b1;
                data_req_valid <= 1'b0;
            end
            waited++;
            assert (waited <= WAIT_LIMIT) else begin
                stop_on_error("Timed out waiting for a request to be accepted");
            end
        end
    endtask

    task automatic wait_responses();
        int waited;
        waited = 0;
        while (fetch_exp.size() != 0 || data_exp.size() != 0) begin
            @(posedge clk);
            waited++;
            assert (waited <= WAIT_LIMIT) else begin
                stop_on_error("Timed out waiting for the expected responses");
            end
        end
    endtask

    task automatic run_op(input op_line_t line);
        mem_unit_pkg::core_req_t req;
        logic                    in_smem;
        logic                    do_fetch;
        logic                    do_data;
        int                      fetch_before;
        int                      data_before;
        in_smem    = line.addr[15:8] == mem_unit_pkg::SMEM_BASE;
        do_fetch   = line.op == OP_FETCH || line.op == OP_PAIR;
        do_data    = line.op != OP_FETCH;
        req.rw     = line.op == OP_STORE;
        req.byteen = line.byteen;
        req.addr   = line.addr;
        req.data   = line.data;
        req.tag    = line.tag;
        if (do_fetch) begin
            fetch_exp.push_back({line.expected, line.tag});
        end
        if (do_data && !req.rw) begin
            data_exp.push_back({line.expected, line.tag});
        end
        fetch_before = n_fetch_xfers;
        data_before  = n_data_xfers;
        issue_requests(do_fetch, do_data, line, req);
        wait_responses();
        @(posedge clk);
        // Each request crosses the mem port once unless it targets shared memory
        check_value("fetch transfers on mem_req", 32'(n_fetch_xfers - fetch_before),
                    32'(do_fetch));
        check_value("data transfers on mem_req", 32'(n_data_xfers - data_before),
                    32'(do_data && !in_smem));
    endtask

    task automatic final_check(input op_line_t line);
        int waited;
        waited = 0;
        while (outstanding != 0 || mem_req_valid) begin
            @(posedge clk);
            waited++;
            assert (waited <= WAIT_LIMIT) else begin
                stop_on_error("Timed out waiting for the mem port to drain");
            end
        end
        repeat (2) @(posedge clk);
        check_value("perf.reads", perf.reads, 32'(n_reads));
        check_value("perf.reads", perf.reads, line.expected);
        check_value("perf.writes", perf.writes, 32'(n_writes));
        check_value("perf.writes", perf.writes, line.data);
        check_value("perf.stalls", perf.stalls, 32'(n_stalls));
        check_value("perf.latency", perf.latency, 32'(lat_sum));
    endtask

    initial begin
        op_line_t line;
        int       idx;
        logic     done;
        for (int i = 0; i < MAX_OPS; i++) begin
            ops[i] = '0;
        end
        $readmemh("test/mem_input.txt", ops);
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        idx  = 0;
        done = 1'b0;
        while (!done) begin
            assert (idx < MAX_OPS) else begin
                stop_on_error("The data file has no final check line");
            end
            line = op_line_t'(ops[idx]);
            idx++;
            case (line.op)
                OP_FINAL: begin
                    final_check(line);
                    done = 1'b1;
                end
                OP_FETCH, OP_LOAD, OP_STORE, OP_PAIR: begin
                    run_op(line);
                end
                default: begin
                    stop_on_error($sformatf("Unknown operation %h on data line %0d",
                                            line.op, idx));
                end
            endcase
        end
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/mem_input.txt ====
// op_addr_byteen_data_tag_expected, one operation per line
// op 1 fetch, 2 load, 3 store, 4 fetch and load together, F final (data writes, expected reads)
3_FF10_F_12345678_1_00000000
3_FF10_5_AABBCCDD_2_00000000
2_FF10_F_00000000_3_12BB56DD
2_0010_F_00000000_4_A5B5A5B5
1_0100_F_00000000_5_A4A5A4A5
3_0020_3_0000BEEF_6_00000000
2_0020_F_00000000_7_A585BEEF
1_0020_F_00000000_8_A585BEEF
3_0200_F_CAFEF00D_9_00000000
2_0200_C_00000000_A_CAFEF00D
1_1234_F_00000000_B_B791B791
4_0300_F_00000000_C_A6A5A6A5
4_0444_F_00000000_D_A1E1A1E1
4_0555_F_00000000_E_A0F0A0F0
4_0AB0_F_00000000_F_AF15AF15
// Just below the shared window
2_FEFF_F_00000000_0_5B5A5B5A
2_FF10_F_00000000_1_12BB56DD
3_FF20_F_0F1E2D3C_2_00000000
2_FF20_F_00000000_3_0F1E2D3C
F_0000_0_00000002_0_0000000F

// ==== mem_unit.f ====
hw/mem_unit_pkg.sv
hw/smem_router.sv
hw/shared_mem.sv
hw/mem_arb.sv
hw/mem_perf_counters.sv
hw/mem_unit.sv
test/tb_mem_unit.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_unit -f mem_unit.f
	@out="$$(./obj_dir/Vtb_mem_unit)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
